/* design/scan_pkg.sv */
// ==========================================================
// Shared constants and types for the I2C bus scanner
// ==========================================================

package scan_pkg;

    // I2C 7-bit address width
    localparam int ADDR_W = 7;

    // One bus address
    typedef logic [ADDR_W-1:0] addr_t;

    // Scan range, reserved addresses at both ends skipped
    localparam addr_t SCAN_FIRST = 7'h08;
    localparam addr_t SCAN_LAST  = 7'h77;

    // Characters used by the report
    localparam logic [7:0] ASCII_SPACE = 8'h20;
    localparam logic [7:0] ASCII_CR    = 8'h0D;
    localparam logic [7:0] ASCII_LF    = 8'h0A;

    // Bus phases of one address probe
    typedef enum logic [2:0] {
        PH_IDLE  = 3'd0,
        // SDA falls with SCL high
        PH_START = 3'd1,
        // Address and write bit, MSB first
        PH_BIT   = 3'd2,
        // Ninth clock, SDA released
        PH_ACK   = 3'd3,
        // SDA rises with SCL high
        PH_STOP  = 3'd4,
        // One-cycle result strobe
        PH_DONE  = 3'd5
    } probe_phase_e;

endpackage

/* design/scan_sequencer.sv */
`timescale 1ns/100ps

// Steps through the address range, one probe at a time
module scan_sequencer (
    input  logic              clk_g,
    input  logic              rst_i,
    input  logic              trig_i,
    input  logic              probe_done_i,
    input  logic              probe_ack_i,
    input  logic              report_busy_i,
    output logic              probe_start_o,
    output scan_pkg::addr_t   probe_addr_o,
    output logic              scan_end_o,
    output logic              busy_o
);

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_LAUNCH,
        SEQ_WAIT_PROBE,
        SEQ_WAIT_REPORT,
        SEQ_FINISH
    } seq_state_e;

    seq_state_e      state_q;
    scan_pkg::addr_t addr_q;
    // Set once CR LF has been requested
    logic            end_sent_q;

    // ==========================================================
    // Scan FSM
    // ==========================================================
    always_ff @(posedge clk_g) begin
        if (rst_i) begin
            state_q    <= SEQ_IDLE;
            addr_q     <= scan_pkg::SCAN_FIRST;
            end_sent_q <= 1'b0;
        end else begin
            case (state_q)
                SEQ_IDLE: begin
                    // Triggers only count here, so a trigger while busy is lost
                    if (trig_i) begin
                        addr_q     <= scan_pkg::SCAN_FIRST;
                        end_sent_q <= 1'b0;
                        state_q    <= SEQ_LAUNCH;
                    end
                end
                SEQ_LAUNCH: begin
                    state_q <= SEQ_WAIT_PROBE;
                end
                SEQ_WAIT_PROBE: begin
                    if (probe_done_i) begin
                        // Found a device, let the report print it first
                        if (probe_ack_i) begin
                            state_q <= SEQ_WAIT_REPORT;
                        end else if (addr_q == scan_pkg::SCAN_LAST) begin
                            state_q <= SEQ_FINISH;
                        end else begin
                            addr_q  <= scan_pkg::addr_t'(addr_q + 1'b1);
                            state_q <= SEQ_LAUNCH;
                        end
                    end
                end
                SEQ_WAIT_REPORT: begin
                    // Report busy is already high on entry
                    if (!report_busy_i) begin
                        if (end_sent_q) begin
                            state_q <= SEQ_IDLE;
                        end else if (addr_q == scan_pkg::SCAN_LAST) begin
                            state_q <= SEQ_FINISH;
                        end else begin
                            addr_q  <= scan_pkg::addr_t'(addr_q + 1'b1);
                            state_q <= SEQ_LAUNCH;
                        end
                    end
                end
                SEQ_FINISH: begin
                    // Line end goes out, then wait for it to drain
                    end_sent_q <= 1'b1;
                    state_q    <= SEQ_WAIT_REPORT;
                end
                default: begin
                    state_q <= SEQ_IDLE;
                end
            endcase
        end
    end

    // Strobes decoded from the state
    assign probe_start_o = (state_q == SEQ_LAUNCH);
    assign scan_end_o    = (state_q == SEQ_FINISH);
    assign probe_addr_o  = addr_q;
    assign busy_o        = (state_q != SEQ_IDLE);

endmodule

/* design/i2c_probe.sv */
`timescale 1ns/100ps

// Single-address I2C probe: START, address + W, ACK sample, STOP
module i2c_probe #(
    parameter int I2C_PRESCALER = 250
) (
    input  logic            clk_g,
    input  logic            rst_i,
    input  logic            start_i,
    input  scan_pkg::addr_t addr_i,
    input  logic            scl_i,
    input  logic            sda_i,
    output logic            done_o,
    output logic            ack_o,
    output logic            scl_t_o,
    output logic            sda_t_o,
    output logic            scl_o,
    output logic            sda_o
);

    localparam int CNT_W = (I2C_PRESCALER > 1) ? $clog2(I2C_PRESCALER) : 1;

    scan_pkg::probe_phase_e phase_q;
    logic [CNT_W-1:0]       cnt_q;
    logic [1:0]             quarter_q;
    logic [2:0]             bit_cnt_q;
    logic [7:0]             shift_q;
    logic                   scl_t_q;
    logic                   sda_t_q;
    logic                   ack_q;
    logic                   stall;
    logic                   tick;

    // SCL released but still read low, target is stretching
    assign stall = scl_t_q && !scl_i;
    // End of one quarter SCL period
    assign tick  = (cnt_q == CNT_W'(I2C_PRESCALER - 1)) && !stall;

    // ==========================================================
    // Quarter-period counter
    // ==========================================================
    always_ff @(posedge clk_g) begin
        if (rst_i || phase_q == scan_pkg::PH_IDLE) begin
            cnt_q <= '0;
        end else if (tick) begin
            cnt_q <= '0;
        end else if (!stall) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // Address and write bit, MSB leaves first
    always_ff @(posedge clk_g) begin
        if (phase_q == scan_pkg::PH_IDLE && start_i) begin
            shift_q <= {addr_i, 1'b0};
        end else if (phase_q == scan_pkg::PH_BIT && tick && quarter_q == 2'd3) begin
            shift_q <= {shift_q[6:0], 1'b0};
        end
    end

    // ==========================================================
    // Phase machine
    // ==========================================================
    always_ff @(posedge clk_g) begin
        if (rst_i) begin
            phase_q   <= scan_pkg::PH_IDLE;
            quarter_q <= 2'd0;
            bit_cnt_q <= 3'd0;
            scl_t_q   <= 1'b1;
            sda_t_q   <= 1'b1;
            ack_q     <= 1'b0;
        end else begin
            case (phase_q)
                scan_pkg::PH_IDLE: begin
                    if (start_i) begin
                        phase_q   <= scan_pkg::PH_START;
                        quarter_q <= 2'd0;
                        ack_q     <= 1'b0;
                    end
                end
                scan_pkg::PH_START: begin
                    if (tick) begin
                        if (quarter_q == 2'd0) begin
                            // SDA low under high SCL
                            sda_t_q   <= 1'b0;
                            quarter_q <= 2'd1;
                        end else begin
                            scl_t_q   <= 1'b0;
                            quarter_q <= 2'd0;
                            bit_cnt_q <= 3'd0;
                            phase_q   <= scan_pkg::PH_BIT;
                        end
                    end
                end
                scan_pkg::PH_BIT: begin
                    if (tick) begin
                        quarter_q <= quarter_q + 2'd1;
                        case (quarter_q)
                            // Data changes only while SCL is low
                            2'd0: sda_t_q <= shift_q[7];
                            2'd1: scl_t_q <= 1'b1;
                            2'd3: begin
                                scl_t_q   <= 1'b0;
                                bit_cnt_q <= bit_cnt_q + 3'd1;
                                if (bit_cnt_q == 3'd7) begin
                                    phase_q <= scan_pkg::PH_ACK;
                                end
                            end
                            default: ;
                        endcase
                    end
                end
                scan_pkg::PH_ACK: begin
                    if (tick) begin
                        quarter_q <= quarter_q + 2'd1;
                        case (quarter_q)
                            2'd0: sda_t_q <= 1'b1;
                            2'd1: scl_t_q <= 1'b1;
                            // Middle of SCL high, target pulls low to acknowledge
                            2'd2: ack_q   <= !sda_i;
                            default: begin
                                scl_t_q <= 1'b0;
                                phase_q <= scan_pkg::PH_STOP;
                            end
                        endcase
                    end
                end
                scan_pkg::PH_STOP: begin
                    if (tick) begin
                        quarter_q <= quarter_q + 2'd1;
                        case (quarter_q)
                            2'd0: sda_t_q <= 1'b0;
                            2'd1: scl_t_q <= 1'b1;
                            // SDA rises under high SCL
                            2'd2: sda_t_q <= 1'b1;
                            default: phase_q <= scan_pkg::PH_DONE;
                        endcase
                    end
                end
                scan_pkg::PH_DONE: begin
                    phase_q <= scan_pkg::PH_IDLE;
                end
                default: begin
                    phase_q <= scan_pkg::PH_IDLE;
                end
            endcase
        end
    end

    assign done_o  = (phase_q == scan_pkg::PH_DONE);
    assign ack_o   = ack_q;
    // Open drain, only ever pull low
    assign scl_t_o = scl_t_q;
    assign sda_t_o = sda_t_q;
    assign scl_o   = 1'b0;
    assign sda_o   = 1'b0;

endmodule

/* design/scan_report.sv */
`timescale 1ns/100ps

// Formats found addresses as hex text and ends the line
module scan_report (
    input  logic            clk_g,
    input  logic            rst_i,
    input  logic            done_i,
    input  logic            ack_i,
    input  scan_pkg::addr_t addr_i,
    input  logic            scan_end_i,
    input  logic            tx_busy_i,
    output logic            busy_o,
    output logic            tx_load_o,
    output logic [7:0]      tx_data_o
);

    scan_pkg::addr_t addr_q;
    logic            busy_q;
    // Line end mode, CR LF instead of hex
    logic            eol_q;
    // Characters still to hand over
    logic [1:0]      remain_q;

    // Nibble to upper-case hex digit
    function automatic logic [7:0] hex_char(input logic [3:0] nib);
        if (nib < 4'd10) begin
            return 8'h30 + {4'h0, nib};
        end
        return 8'h37 + {4'h0, nib};
    endfunction

    // Address kept for the three characters
    always_ff @(posedge clk_g) begin
        if (done_i && ack_i) begin
            addr_q <= addr_i;
        end
    end

    // ==========================================================
    // Character counter
    // ==========================================================
    always_ff @(posedge clk_g) begin
        if (rst_i) begin
            busy_q   <= 1'b0;
            eol_q    <= 1'b0;
            remain_q <= 2'd0;
        end else if (done_i && ack_i) begin
            // Two digits and a space
            busy_q   <= 1'b1;
            eol_q    <= 1'b0;
            remain_q <= 2'd3;
        end else if (scan_end_i) begin
            busy_q   <= 1'b1;
            eol_q    <= 1'b1;
            remain_q <= 2'd2;
        end else if (tx_load_o) begin
            remain_q <= remain_q - 2'd1;
        end else if (busy_q && remain_q == 2'd0 && !tx_busy_i) begin
            // Last stop bit is out
            busy_q <= 1'b0;
        end
    end

    // One load per idle period, tx busy follows on the next cycle
    assign tx_load_o = busy_q && (remain_q != 2'd0) && !tx_busy_i;

    // Character picked by mode and count
    always_comb begin
        case ({eol_q, remain_q})
            3'b0_11: tx_data_o = hex_char({1'b0, addr_q[6:4]});
            3'b0_10: tx_data_o = hex_char(addr_q[3:0]);
            3'b1_10: tx_data_o = scan_pkg::ASCII_CR;
            3'b1_01: tx_data_o = scan_pkg::ASCII_LF;
            default: tx_data_o = scan_pkg::ASCII_SPACE;
        endcase
    end

    assign busy_o = busy_q;

endmodule

/* design/uart_tx.sv */
`timescale 1ns/100ps

// 8N1 UART transmitter
module uart_tx #(
    parameter int UART_PRESCALER = 868
) (
    input  logic       clk_g,
    input  logic       rst_i,
    input  logic       load_i,
    input  logic [7:0] data_i,
    output logic       busy_o,
    output logic       tx_o
);

    localparam int CNT_W = (UART_PRESCALER > 1) ? $clog2(UART_PRESCALER) : 1;

    logic [CNT_W-1:0] div_q;
    logic [9:0]       shift_q;
    logic [3:0]       bits_q;
    logic             bit_end;

    // Last clock of one bit time
    assign bit_end = (div_q == CNT_W'(UART_PRESCALER - 1));

    // ==========================================================
    // Bit timing and shift register
    // ==========================================================
    always_ff @(posedge clk_g) begin
        if (rst_i) begin
            div_q   <= '0;
            bits_q  <= 4'd0;
            // Line idles high
            shift_q <= '1;
        end else if (load_i && bits_q == 4'd0) begin
            // Stop, data LSB first, start
            shift_q <= {1'b1, data_i, 1'b0};
            bits_q  <= 4'd10;
            div_q   <= '0;
        end else if (bits_q != 4'd0) begin
            if (bit_end) begin
                div_q   <= '0;
                shift_q <= {1'b1, shift_q[9:1]};
                bits_q  <= bits_q - 4'd1;
            end else begin
                div_q <= div_q + 1'b1;
            end
        end
    end

    assign busy_o = (bits_q != 4'd0);
    assign tx_o   = shift_q[0];

endmodule

/* design/scan_top.sv */
`timescale 1ns/100ps

// I2C bus scanner with UART report
module scan_top #(
    parameter int UART_PRESCALER = 868,
    parameter int I2C_PRESCALER  = 250
) (
    input  logic clk_g,
    input  logic rst_i,
    input  logic trig_i,
    output logic busy_o,
    output logic tx_o,
    input  logic scl_i,
    output logic scl_o,
    output logic scl_t_o,
    input  logic sda_i,
    output logic sda_o,
    output logic sda_t_o
);

    // Sequencer and probe
    logic            probe_start;
    scan_pkg::addr_t probe_addr;
    logic            probe_done;
    logic            probe_ack;
    // Report side
    logic            scan_end;
    logic            report_busy;
    // Transmitter side
    logic            tx_load;
    logic [7:0]      tx_data;
    logic            tx_busy;

    // ==========================================================
    // Decode, execute, result, serial out
    // ==========================================================
    scan_sequencer u_sequencer (
        .clk_g         (clk_g),
        .rst_i         (rst_i),
        .trig_i        (trig_i),
        .probe_done_i  (probe_done),
        .probe_ack_i   (probe_ack),
        .report_busy_i (report_busy),
        .probe_start_o (probe_start),
        .probe_addr_o  (probe_addr),
        .scan_end_o    (scan_end),
        .busy_o        (busy_o)
    );

    i2c_probe #(
        .I2C_PRESCALER (I2C_PRESCALER)
    ) u_probe (
        .clk_g   (clk_g),
        .rst_i   (rst_i),
        .start_i (probe_start),
        .addr_i  (probe_addr),
        .scl_i   (scl_i),
        .sda_i   (sda_i),
        .done_o  (probe_done),
        .ack_o   (probe_ack),
        .scl_t_o (scl_t_o),
        .sda_t_o (sda_t_o),
        .scl_o   (scl_o),
        .sda_o   (sda_o)
    );

    scan_report u_report (
        .clk_g      (clk_g),
        .rst_i      (rst_i),
        .done_i     (probe_done),
        .ack_i      (probe_ack),
        .addr_i     (probe_addr),
        .scan_end_i (scan_end),
        .tx_busy_i  (tx_busy),
        .busy_o     (report_busy),
        .tx_load_o  (tx_load),
        .tx_data_o  (tx_data)
    );

    uart_tx #(
        .UART_PRESCALER (UART_PRESCALER)
    ) u_uart_tx (
        .clk_g  (clk_g),
        .rst_i  (rst_i),
        .load_i (tx_load),
        .data_i (tx_data),
        .busy_o (tx_busy),
        .tx_o   (tx_o)
    );

endmodule

/* sim/i2c_target_model.sv */
`timescale 1ns/100ps

// Behavioral I2C targets on a wired-AND bus
module i2c_target_model #(
    // Nominal SCL low time of the DUT in clock cycles
    parameter int         LOW_CYCLES = 8,
    parameter logic [6:0] TARGET_0   = 7'h1A,
    parameter logic [6:0] TARGET_1   = 7'h50,
    parameter logic [6:0] TARGET_2   = 7'h68
) (
    input  logic clk_g,
    input  logic rst_i,
    input  logic ack_en_i,
    input  logic stretch_en_i,
    input  logic scl_i,
    input  logic sda_i,
    output logic scl_pull_o,
    output logic sda_pull_o,
    output int   mismatch_o,
    output int   protocol_o
);

    logic       scl_q;
    logic       sda_q;
    // Between START and STOP
    logic       in_txn_q;
    // SCL rising edges since START
    logic [3:0] bits_q;
    logic [7:0] byte_q;
    // Address the next probe must carry
    logic [6:0] next_addr_q;
    int         hold_q;
    logic       matched;

    // Address byte hits one of the targets, write bit clear
    assign matched = ack_en_i && !byte_q[0] && (byte_q[7:1] == TARGET_0 ||
                     byte_q[7:1] == TARGET_1 || byte_q[7:1] == TARGET_2);

    always @(posedge clk_g) begin
        if (rst_i) begin
            scl_q       <= 1'b1;
            sda_q       <= 1'b1;
            in_txn_q    <= 1'b0;
            bits_q      <= 4'd0;
            byte_q      <= 8'h00;
            next_addr_q <= scan_pkg::SCAN_FIRST;
            hold_q      <= 0;
            scl_pull_o  <= 1'b0;
            sda_pull_o  <= 1'b0;
            mismatch_o  <= 0;
            protocol_o  <= 0;
        end else begin
            scl_q <= scl_i;
            sda_q <= sda_i;

            // ==========================================================
            // SDA moving under high SCL, only START or STOP
            // ==========================================================
            if (scl_q && scl_i && sda_q != sda_i) begin
                if (!sda_i) begin
                    assert (!in_txn_q) else begin
                        protocol_o <= protocol_o + 1;
                        $display("SDA fell under high SCL inside a probe at %0t", $time);
                    end
                    in_txn_q <= 1'b1;
                    bits_q   <= 4'd0;
                end else begin
                    // Nine byte clocks plus the clock before STOP
                    assert (in_txn_q && bits_q == 4'd10) else begin
                        protocol_o <= protocol_o + 1;
                        $display("SDA rose under high SCL before the probe ended at %0t",
                                 $time);
                    end
                    in_txn_q    <= 1'b0;
                    next_addr_q <= (next_addr_q == scan_pkg::SCAN_LAST) ?
                                   scan_pkg::SCAN_FIRST : next_addr_q + 7'd1;
                end
            end

            // Rising SCL samples data
            if (!scl_q && scl_i) begin
                assert (in_txn_q) else begin
                    protocol_o <= protocol_o + 1;
                    $display("SCL clocked without a START at %0t", $time);
                end
                bits_q <= bits_q + 4'd1;
                if (bits_q < 4'd8) begin
                    byte_q <= {byte_q[6:0], sda_i};
                end
                // Ninth clock, whole byte is in
                if (bits_q == 4'd8) begin
                    assert (byte_q == {next_addr_q, 1'b0}) else begin
                        mismatch_o <= mismatch_o + 1;
                        $display("MISMATCH time=%0t signal=address_byte expected=%h actual=%h",
                                 $time, {next_addr_q, 1'b0}, byte_q);
                    end
                end
            end

            // Falling SCL, ACK drive and stretch
            if (scl_q && !scl_i) begin
                sda_pull_o <= (bits_q == 4'd8) && matched;
                if (stretch_en_i) begin
                    // Zero extra lines up with the DUT's own release
                    scl_pull_o <= 1'b1;
                    hold_q     <= LOW_CYCLES - 2 + int'($urandom % 8);
                end
            end else if (hold_q > 0) begin
                hold_q <= hold_q - 1;
            end else begin
                scl_pull_o <= 1'b0;
            end
        end
    end

endmodule

/* sim/tb_scan_top.sv */
`timescale 1ns/100ps

module tb_scan_top;

    localparam int         SEED_VAL       = 32'h046a3362;
    localparam int         CLK_PERIOD     = 40;
    localparam int         RESET_CYCLES   = 16;
    localparam int         UART_DIV       = 8;
    localparam int         I2C_DIV        = 4;
    // Deliberately unsorted
    localparam logic [6:0] TARGETS [3]    = '{7'h68, 7'h1A, 7'h50};
    // Three character times of silence after a scan
    localparam int         QUIET_CYCLES   = 30 * UART_DIV;
    localparam int         TIMEOUT_CYCLES = 2 * 3 * (112 * 4 * 4 * 11 + 12 * 80);

    logic       clk_g;
    logic       rst_i;
    logic       trig_i;
    logic       busy;
    logic       tx;
    logic       scl_bus;
    logic       scl_drv;
    logic       scl_t;
    logic       scl_pull;
    logic       sda_bus;
    logic       sda_drv;
    logic       sda_t;
    logic       sda_pull;
    logic       ack_en;
    logic       stretch_en;
    // Window where the DUT must sit quiet
    logic       idle_check;
    int         mism_errors  = 0;
    int         proto_errors = 0;
    int         model_mism;
    int         model_proto;
    int         cycle_cnt    = 0;
    // Clocks in a row with the serial line high
    int         tx_high_cnt  = 0;
    logic [7:0] rx_q[$];
    logic [7:0] exp_q[$];
    string      hex_digits   = "0123456789ABCDEF";

    // Wired-AND, low if either side pulls
    assign scl_bus = (scl_t ? 1'b1 : scl_drv) & ~scl_pull;
    assign sda_bus = (sda_t ? 1'b1 : sda_drv) & ~sda_pull;

    scan_top #(
        .UART_PRESCALER (UART_DIV),
        .I2C_PRESCALER  (I2C_DIV)
    ) dut (
        .clk_g   (clk_g),
        .rst_i   (rst_i),
        .trig_i  (trig_i),
        .busy_o  (busy),
        .tx_o    (tx),
        .scl_i   (scl_bus),
        .scl_o   (scl_drv),
        .scl_t_o (scl_t),
        .sda_i   (sda_bus),
        .sda_o   (sda_drv),
        .sda_t_o (sda_t)
    );

    i2c_target_model #(
        .LOW_CYCLES (2 * I2C_DIV),
        .TARGET_0   (TARGETS[0]),
        .TARGET_1   (TARGETS[1]),
        .TARGET_2   (TARGETS[2])
    ) targets (
        .clk_g        (clk_g),
        .rst_i        (rst_i),
        .ack_en_i     (ack_en),
        .stretch_en_i (stretch_en),
        .scl_i        (scl_bus),
        .sda_i        (sda_bus),
        .scl_pull_o   (scl_pull),
        .sda_pull_o   (sda_pull),
        .mismatch_o   (model_mism),
        .protocol_o   (model_proto)
    );

    initial begin
        clk_g = 1'b0;
        forever #(CLK_PERIOD / 2) clk_g = ~clk_g;
    end

    function automatic void note_mismatch(input string name, input int exp_v, input int act_v);
        mism_errors++;
        $display("MISMATCH time=%0t signal=%s expected=%h actual=%h", $time, name, exp_v, act_v);
    endfunction

    // ==========================================================
    // Quiet state while idle
    // ==========================================================
    assert property (@(posedge clk_g) idle_check |-> busy == 1'b0)
        else note_mismatch("busy_o", 0, int'($sampled(busy)));
    assert property (@(posedge clk_g) idle_check |-> tx == 1'b1)
        else note_mismatch("tx_o", 1, int'($sampled(tx)));
    assert property (@(posedge clk_g) idle_check |-> scl_t == 1'b1)
        else note_mismatch("scl_t_o", 1, int'($sampled(scl_t)));
    assert property (@(posedge clk_g) idle_check |-> sda_t == 1'b1)
        else note_mismatch("sda_t_o", 1, int'($sampled(sda_t)));

    // Open-drain pins only ever drive low
    assert property (@(posedge clk_g) scl_drv == 1'b0)
        else note_mismatch("scl_o", 0, int'($sampled(scl_drv)));
    assert property (@(posedge clk_g) sda_drv == 1'b0)
        else note_mismatch("sda_o", 0, int'($sampled(sda_drv)));

    // Line must have been high for a whole stop bit when busy drops
    always @(posedge clk_g) begin
        tx_high_cnt <= (tx == 1'b1) ? tx_high_cnt + 1 : 0;
    end

    assert property (@(posedge clk_g) disable iff (rst_i)
                     $fell(busy) |-> tx_high_cnt >= UART_DIV)
        else begin
            proto_errors++;
            $display("busy_o fell before the last stop bit was complete at %0t", $time);
        end

    // UART receiver, samples at bit centers
    always begin : uart_rx
        logic [7:0] ch;
        @(posedge clk_g);
        if (!rst_i && tx == 1'b0) begin
            repeat (UART_DIV / 2) @(posedge clk_g);
            assert (tx == 1'b0) else begin
                proto_errors++;
                $display("UART start bit shorter than half a bit at %0t", $time);
            end
            for (int i = 0; i < 8; i++) begin
                repeat (UART_DIV) @(posedge clk_g);
                ch[i] = tx;
            end
            repeat (UART_DIV) @(posedge clk_g);
            assert (tx == 1'b1) else begin
                proto_errors++;
                $display("UART stop bit missing at %0t", $time);
            end
            rx_q.push_back(ch);
        end
    end

    // Sorted targets as hex pairs with a space, then CR LF
    function automatic void build_expected(input logic with_targets);
        logic [6:0] sorted[$];
        exp_q.delete();
        if (with_targets) begin
            foreach (TARGETS[i]) begin
                sorted.push_back(TARGETS[i]);
            end
            sorted.sort();
            foreach (sorted[i]) begin
                exp_q.push_back(hex_digits.getc(int'(sorted[i][6:4])));
                exp_q.push_back(hex_digits.getc(int'(sorted[i][3:0])));
                exp_q.push_back(8'h20);
            end
        end
        exp_q.push_back(8'h0D);
        exp_q.push_back(8'h0A);
    endfunction

    function automatic void check_line();
        assert (rx_q.size() == exp_q.size()) else begin
            note_mismatch("line_length", exp_q.size(), rx_q.size());
        end
        foreach (exp_q[i]) begin
            if (i < rx_q.size()) begin
                assert (rx_q[i] == exp_q[i]) else begin
                    note_mismatch($sformatf("tx_o_char%0d", i), int'(exp_q[i]), int'(rx_q[i]));
                end
            end
        end
    endfunction

    // One trigger, optional second trigger mid-scan, then the line check
    task automatic run_scan(input logic retrigger);
        int gap;
        gap = 200 + int'($urandom % 400);
        @(posedge clk_g);
        trig_i     <= 1'b1;
        idle_check <= 1'b0;
        @(posedge clk_g);
        trig_i <= 1'b0;
        @(posedge clk_g);
        assert (busy == 1'b1) else begin
            proto_errors++;
            $display("busy_o did not rise after the trigger at %0t", $time);
        end
        if (retrigger) begin
            repeat (gap) @(posedge clk_g);
            assert (busy == 1'b1) else begin
                proto_errors++;
                $display("Scan ended before the second trigger at %0t", $time);
            end
            trig_i <= 1'b1;
            @(posedge clk_g);
            trig_i <= 1'b0;
        end
        while (busy) @(posedge clk_g);
        // LF fully received before busy drops
        assert (rx_q.size() > 0 && rx_q[rx_q.size() - 1] == 8'h0A) else begin
            proto_errors++;
            $display("busy_o fell before the line end arrived at %0t", $time);
        end
        check_line();
        rx_q.delete();
        idle_check <= 1'b1;
        repeat (QUIET_CYCLES) @(posedge clk_g);
        assert (rx_q.size() == 0) else begin
            proto_errors++;
            $display("Characters arrived after the scan had ended at %0t", $time);
        end
    endtask

    // ==========================================================
    // Main sequence
    // ==========================================================
    initial begin : main
        int total;
        void'($urandom(SEED_VAL));
        rst_i      = 1'b1;
        trig_i     = 1'b0;
        ack_en     = 1'b0;
        stretch_en = 1'b0;
        idle_check = 1'b0;
        @(posedge clk_g);
        idle_check <= 1'b1;
        repeat (RESET_CYCLES - 1) @(posedge clk_g);
        rst_i <= 1'b0;
        repeat (20) @(posedge clk_g);

        // Three targets, with a trigger while busy
        ack_en <= 1'b1;
        build_expected(1'b1);
        run_scan(1'b1);

        // Nobody answers
        ack_en <= 1'b0;
        build_expected(1'b0);
        run_scan(1'b0);

        // Targets stretch SCL, same line expected
        ack_en     <= 1'b1;
        stretch_en <= 1'b1;
        build_expected(1'b1);
        run_scan(1'b0);

        total = mism_errors + model_mism + proto_errors + model_proto;
        $display("Error counts: mismatches %0d, protocol %0d",
                 mism_errors + model_mism, proto_errors + model_proto);
        if (total == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Run limit
    always @(posedge clk_g) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, a scan never finished", cycle_cnt);
            $display("Regression failed");
            $finish;
        end
    end

endmodule

/* verilog.f */
design/scan_pkg.sv
design/scan_sequencer.sv
design/i2c_probe.sv
design/scan_report.sv
design/uart_tx.sv
design/scan_top.sv
sim/i2c_target_model.sv
sim/tb_scan_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the scanner testbench with Verilator, result taken from sim.log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f verilog.f --top-module tb_scan_top -o tb_scan_top \
    > sim.log 2>&1 \
    && ./obj_dir/tb_scan_top >> sim.log 2>&1 \
    || echo "Build or simulation exited with an error" >> sim.log
if grep -q "Regression failed" sim.log || ! grep -q "Regression passed" sim.log; then
    echo "FAIL, see sim.log"
    exit 1
fi
echo "PASS"
exit 0
